// File: Bender.yml
package:
  name: amber_periph_system

sources:
  # shared package first
  - common/amber_pkg.sv
  # slaves and fabric
  - boot_mem/boot_mem.sv
  - timer/timer_module.sv
  - irq/interrupt_controller.sv
  - logic/test_module.sv
  - logic/wb_decoder.sv
  - logic/amber_periph_system.sv
  # verification
  - target: test
    files:
      - testbench/amber_periph_system_sva.sv
      - testbench/tb_amber_periph_system.sv

// File: boot_mem/boot_mem.sv
`timescale 1ns/1ns

module boot_mem #(
    parameter int WORDS = amber_pkg::BOOT_MEM_WORDS
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_wr,
    input  amber_pkg::wb_adr_t i_adr,
    input  amber_pkg::wb_sel_t i_sel,
    input  amber_pkg::wb_dat_t i_dat,
    output amber_pkg::wb_dat_t o_rdat
);
    import amber_pkg::*;

    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    wb_dat_t         mem [WORDS];
    logic [AW-1:0]   idx;

    // word index above the byte offset, wraps at WORDS
    assign idx = AW'(i_adr[WB_AWIDTH-1:2] % WORDS);

    // async read of current contents
    assign o_rdat = mem[idx];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int w = 0; w < WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (i_wr) begin
            // only selected bytes change
            mem[idx] <= byte_merge(mem[idx], i_dat, i_sel);
        end
    end

endmodule

// File: common/amber_pkg.sv
package amber_pkg;

    // --------------------------------------------------
    // wishbone bus
    // --------------------------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    typedef logic [WB_DWIDTH-1:0] wb_dat_t;
    typedef logic [WB_SWIDTH-1:0] wb_sel_t;
    typedef logic [WB_AWIDTH-1:0] wb_adr_t;

    // --------------------------------------------------
    // address map
    // --------------------------------------------------
    // region is the top address byte
    localparam logic [7:0] REGION_BOOT_MEM = 8'h00;
    localparam logic [7:0] REGION_TIMER    = 8'h13;
    localparam logic [7:0] REGION_IRQ      = 8'h14;
    localparam logic [7:0] REGION_TEST     = 8'hF0;

    // decoded targets, SLV_NONE for anything unmapped
    typedef enum logic [2:0] {
        SLV_BOOT_MEM,
        SLV_TIMER,
        SLV_IRQ,
        SLV_TEST,
        SLV_NONE
    } slave_e;

    // default sizes
    localparam int BOOT_MEM_WORDS = 2048;
    localparam int N_TIMERS       = 3;
    localparam int N_IRQ_SRC      = 8;

    // interrupt source bit positions, others tied low
    typedef enum int unsigned {
        SRC_TEST   = 1,
        SRC_TIMER0 = 2,
        SRC_TIMER1 = 3,
        SRC_TIMER2 = 4
    } irq_src_e;

    // timer registers, adr[3:2]; timer index in adr[9:8]
    typedef enum logic [1:0] {
        TMR_LOAD  = 2'd0,
        TMR_VALUE = 2'd1,
        TMR_CTRL  = 2'd2,
        TMR_CLR   = 2'd3
    } tmr_reg_e;

    localparam int TMR_CTRL_EN_BIT  = 7;
    localparam int TMR_CTRL_PER_BIT = 6;

    // interrupt controller registers, adr[5:2]
    typedef enum logic [3:0] {
        IRQ_STATUS  = 4'd0,
        IRQ_RAW     = 4'd1,
        IRQ_EN_SET  = 4'd2,
        IRQ_EN_CLR  = 4'd3,
        FIRQ_STATUS = 4'd8,
        FIRQ_RAW    = 4'd9,
        FIRQ_EN_SET = 4'd10,
        FIRQ_EN_CLR = 4'd11
    } irq_reg_e;

    // test module registers, adr[3:2]
    typedef enum logic [1:0] {
        TST_LED  = 2'd0,
        TST_IRQ  = 2'd1,
        TST_FIRQ = 2'd2,
        TST_ID   = 2'd3
    } test_reg_e;

    localparam wb_dat_t TEST_ID_VALUE = 32'hA23_0001;

    // replace only the bytes whose select bit is set
    function automatic wb_dat_t byte_merge(wb_dat_t old_dat, wb_dat_t new_dat, wb_sel_t sel);
        wb_dat_t res;
        res = old_dat;
        for (int b = 0; b < WB_SWIDTH; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_dat[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: irq/interrupt_controller.sv
`timescale 1ns/1ns

module interrupt_controller #(
    parameter int N_TIMERS = amber_pkg::N_TIMERS
) (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_wr,
    input  amber_pkg::wb_adr_t  i_adr,
    input  amber_pkg::wb_dat_t  i_dat,
    output amber_pkg::wb_dat_t  o_rdat,
    input  logic                i_test_irq,
    input  logic                i_test_firq,
    input  logic [N_TIMERS-1:0] i_timer_int,
    output logic                o_irq,
    output logic                o_firq
);
    import amber_pkg::*;

    logic [N_IRQ_SRC-1:0] irq_raw;
    logic [N_IRQ_SRC-1:0] firq_raw;
    logic [N_IRQ_SRC-1:0] irq_en;
    logic [N_IRQ_SRC-1:0] firq_en;
    logic [N_IRQ_SRC-1:0] irq_status;
    logic [N_IRQ_SRC-1:0] firq_status;
    irq_reg_e             reg_sel;

    assign reg_sel = irq_reg_e'(i_adr[5:2]);

    // raw source vectors, timers feed both
    always_comb begin
        irq_raw  = '0;
        firq_raw = '0;
        irq_raw[SRC_TEST]  = i_test_irq;
        firq_raw[SRC_TEST] = i_test_firq;
        for (int k = 0; k < N_TIMERS; k++) begin
            if (int'(SRC_TIMER0) + k < N_IRQ_SRC) begin
                irq_raw[int'(SRC_TIMER0) + k]  = i_timer_int[k];
                firq_raw[int'(SRC_TIMER0) + k] = i_timer_int[k];
            end
        end
    end

    assign irq_status  = irq_raw & irq_en;
    assign firq_status = firq_raw & firq_en;

    // read mux, set/clear offsets read back the mask
    always_comb begin
        o_rdat = '0;
        case (reg_sel)
            IRQ_STATUS:               o_rdat[N_IRQ_SRC-1:0] = irq_status;
            IRQ_RAW:                  o_rdat[N_IRQ_SRC-1:0] = irq_raw;
            IRQ_EN_SET, IRQ_EN_CLR:   o_rdat[N_IRQ_SRC-1:0] = irq_en;
            FIRQ_STATUS:              o_rdat[N_IRQ_SRC-1:0] = firq_status;
            FIRQ_RAW:                 o_rdat[N_IRQ_SRC-1:0] = firq_raw;
            FIRQ_EN_SET, FIRQ_EN_CLR: o_rdat[N_IRQ_SRC-1:0] = firq_en;
            default:                  o_rdat = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            irq_en  <= '0;
            firq_en <= '0;
            o_irq   <= 1'b0;
            o_firq  <= 1'b0;
        end else begin
            if (i_wr) begin
                case (reg_sel)
                    IRQ_EN_SET:  irq_en  <= irq_en | i_dat[N_IRQ_SRC-1:0];
                    IRQ_EN_CLR:  irq_en  <= irq_en & ~i_dat[N_IRQ_SRC-1:0];
                    FIRQ_EN_SET: firq_en <= firq_en | i_dat[N_IRQ_SRC-1:0];
                    FIRQ_EN_CLR: firq_en <= firq_en & ~i_dat[N_IRQ_SRC-1:0];
                    default: ;
                endcase
            end
            // one cycle behind the masked sources
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
        end
    end

endmodule

// File: logic/amber_periph_system.sv
`timescale 1ns/1ns

module amber_periph_system #(
    parameter int BOOT_MEM_WORDS = amber_pkg::BOOT_MEM_WORDS,
    parameter int N_TIMERS       = amber_pkg::N_TIMERS
) (
    input  logic               i_clk,
    input  logic               i_arst_n,

    // bus from the master
    input  amber_pkg::wb_adr_t i_wb_adr,
    input  amber_pkg::wb_sel_t i_wb_sel,
    input  logic               i_wb_we,
    input  amber_pkg::wb_dat_t i_wb_dat,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    output amber_pkg::wb_dat_t o_wb_dat,
    output logic               o_wb_ack,
    output logic               o_wb_err,

    // interrupts to the core, board led
    output logic               o_irq,
    output logic               o_firq,
    output logic               o_led
);
    import amber_pkg::*;

    // per-slave write strobes
    logic boot_wr;
    logic timer_wr;
    logic irq_wr;
    logic test_wr;

    // per-slave read data
    wb_dat_t boot_rdat;
    wb_dat_t timer_rdat;
    wb_dat_t irq_rdat;
    wb_dat_t test_rdat;

    // interrupt levels
    logic [N_TIMERS-1:0] timer_int;
    logic                test_irq;
    logic                test_firq;

    // --------------------------------------------------
    // decoder
    // --------------------------------------------------
    wb_decoder u_wb_decoder (
        .i_clk        ( i_clk      ),
        .i_arst_n     ( i_arst_n   ),
        .i_wb_adr     ( i_wb_adr   ),
        .i_wb_sel     ( i_wb_sel   ),
        .i_wb_we      ( i_wb_we    ),
        .i_wb_dat     ( i_wb_dat   ),
        .i_wb_cyc     ( i_wb_cyc   ),
        .i_wb_stb     ( i_wb_stb   ),
        .o_wb_dat     ( o_wb_dat   ),
        .o_wb_ack     ( o_wb_ack   ),
        .o_wb_err     ( o_wb_err   ),
        .o_boot_wr    ( boot_wr    ),
        .o_timer_wr   ( timer_wr   ),
        .o_irq_wr     ( irq_wr     ),
        .o_test_wr    ( test_wr    ),
        .i_boot_rdat  ( boot_rdat  ),
        .i_timer_rdat ( timer_rdat ),
        .i_irq_rdat   ( irq_rdat   ),
        .i_test_rdat  ( test_rdat  )
    );

    // --------------------------------------------------
    // slaves
    // --------------------------------------------------
    boot_mem #(
        .WORDS ( BOOT_MEM_WORDS )
    ) u_boot_mem (
        .i_clk    ( i_clk     ),
        .i_arst_n ( i_arst_n  ),
        .i_wr     ( boot_wr   ),
        .i_adr    ( i_wb_adr  ),
        .i_sel    ( i_wb_sel  ),
        .i_dat    ( i_wb_dat  ),
        .o_rdat   ( boot_rdat )
    );

    timer_module #(
        .N ( N_TIMERS )
    ) u_timer_module (
        .i_clk       ( i_clk      ),
        .i_arst_n    ( i_arst_n   ),
        .i_wr        ( timer_wr   ),
        .i_adr       ( i_wb_adr   ),
        .i_sel       ( i_wb_sel   ),
        .i_dat       ( i_wb_dat   ),
        .o_rdat      ( timer_rdat ),
        .o_timer_int ( timer_int  )
    );

    interrupt_controller #(
        .N_TIMERS ( N_TIMERS )
    ) u_interrupt_controller (
        .i_clk       ( i_clk     ),
        .i_arst_n    ( i_arst_n  ),
        .i_wr        ( irq_wr    ),
        .i_adr       ( i_wb_adr  ),
        .i_dat       ( i_wb_dat  ),
        .o_rdat      ( irq_rdat  ),
        .i_test_irq  ( test_irq  ),
        .i_test_firq ( test_firq ),
        .i_timer_int ( timer_int ),
        .o_irq       ( o_irq     ),
        .o_firq      ( o_firq    )
    );

    test_module u_test_module (
        .i_clk       ( i_clk     ),
        .i_arst_n    ( i_arst_n  ),
        .i_wr        ( test_wr   ),
        .i_adr       ( i_wb_adr  ),
        .i_dat       ( i_wb_dat  ),
        .o_rdat      ( test_rdat ),
        .o_led       ( o_led     ),
        .o_test_irq  ( test_irq  ),
        .o_test_firq ( test_firq )
    );

endmodule

// File: logic/test_module.sv
`timescale 1ns/1ns

module test_module (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_wr,
    input  amber_pkg::wb_adr_t i_adr,
    input  amber_pkg::wb_dat_t i_dat,
    output amber_pkg::wb_dat_t o_rdat,
    output logic               o_led,
    output logic               o_test_irq,
    output logic               o_test_firq
);
    import amber_pkg::*;

    test_reg_e reg_sel;

    assign reg_sel = test_reg_e'(i_adr[3:2]);

    // read mux, single bits in bit 0
    always_comb begin
        o_rdat = '0;
        case (reg_sel)
            TST_LED:  o_rdat[0] = o_led;
            TST_IRQ:  o_rdat[0] = o_test_irq;
            TST_FIRQ: o_rdat[0] = o_test_firq;
            TST_ID:   o_rdat    = TEST_ID_VALUE;
            default:  o_rdat    = '0;
        endcase
    end

    // software-driven levels
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_led       <= 1'b0;
            o_test_irq  <= 1'b0;
            o_test_firq <= 1'b0;
        end else if (i_wr) begin
            case (reg_sel)
                TST_LED:  o_led       <= i_dat[0];
                TST_IRQ:  o_test_irq  <= i_dat[0];
                TST_FIRQ: o_test_firq <= i_dat[0];
                default: ;
            endcase
        end
    end

endmodule

// File: logic/wb_decoder.sv
`timescale 1ns/1ns

module wb_decoder (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  amber_pkg::wb_adr_t i_wb_adr,
    input  amber_pkg::wb_sel_t i_wb_sel,
    input  logic               i_wb_we,
    input  amber_pkg::wb_dat_t i_wb_dat,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    output amber_pkg::wb_dat_t o_wb_dat,
    output logic               o_wb_ack,
    output logic               o_wb_err,
    output logic               o_boot_wr,
    output logic               o_timer_wr,
    output logic               o_irq_wr,
    output logic               o_test_wr,
    input  amber_pkg::wb_dat_t i_boot_rdat,
    input  amber_pkg::wb_dat_t i_timer_rdat,
    input  amber_pkg::wb_dat_t i_irq_rdat,
    input  amber_pkg::wb_dat_t i_test_rdat
);
    import amber_pkg::*;

    slave_e  slv;
    logic    accept;
    logic    wr;
    logic    sel_any;
    wb_dat_t rdat_mux;

    // region decode on top address byte
    always_comb begin
        case (i_wb_adr[WB_AWIDTH-1 -: 8])
            REGION_BOOT_MEM: slv = SLV_BOOT_MEM;
            REGION_TIMER:    slv = SLV_TIMER;
            REGION_IRQ:      slv = SLV_IRQ;
            REGION_TEST:     slv = SLV_TEST;
            default:         slv = SLV_NONE;
        endcase
    end

    // one access per handshake, blocked while ack/err is out
    assign accept = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~o_wb_err;
    // partial selects still count as a write for the slave
    assign sel_any = |i_wb_sel;
    assign wr     = accept & i_wb_we & sel_any;

    assign o_boot_wr  = wr & (slv == SLV_BOOT_MEM);
    assign o_timer_wr = wr & (slv == SLV_TIMER);
    assign o_irq_wr   = wr & (slv == SLV_IRQ);
    assign o_test_wr  = wr & (slv == SLV_TEST);

    // read select, unmapped reads zero
    always_comb begin
        case (slv)
            SLV_BOOT_MEM: rdat_mux = i_boot_rdat;
            SLV_TIMER:    rdat_mux = i_timer_rdat;
            SLV_IRQ:      rdat_mux = i_irq_rdat;
            SLV_TEST:     rdat_mux = i_test_rdat;
            default:      rdat_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            o_wb_dat <= '0;
        end else begin
            // single-cycle response
            o_wb_ack <= accept & (slv != SLV_NONE);
            o_wb_err <= accept & (slv == SLV_NONE);
            if (accept) begin
                o_wb_dat <= rdat_mux;
            end
        end
    end

endmodule

// File: project.f
common/amber_pkg.sv
boot_mem/boot_mem.sv
timer/timer_module.sv
irq/interrupt_controller.sv
logic/test_module.sv
logic/wb_decoder.sv
logic/amber_periph_system.sv
testbench/amber_periph_system_sva.sv
testbench/tb_amber_periph_system.sv

// File: testbench/amber_periph_system_sva.sv
`timescale 1ns/1ns

module amber_periph_system_sva (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_wb_stb,
    input logic o_wb_ack,
    input logic o_wb_err
);

    // number of failed assertions
    int n_fail = 0;

    // --------------------------------------------------
    // wishbone response rules
    // --------------------------------------------------
    // never both responses at once
    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_wb_ack && o_wb_err))
        else begin
            $error("ack and err high together");
            n_fail++;
        end

    // single-cycle acknowledge
    a_ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb_ack |=> !o_wb_ack)
        else begin
            $error("ack held longer than one cycle");
            n_fail++;
        end

    // response only after a strobe
    a_resp_after_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_wb_ack || o_wb_err) |-> $past(i_wb_stb))
        else begin
            $error("response without a preceding strobe");
            n_fail++;
        end

endmodule

bind amber_periph_system amber_periph_system_sva u_sva (
    .i_clk    ( i_clk    ),
    .i_arst_n ( i_arst_n ),
    .i_wb_stb ( i_wb_stb ),
    .o_wb_ack ( o_wb_ack ),
    .o_wb_err ( o_wb_err )
);

// File: testbench/tb_amber_periph_system.sv
`timescale 1ns/1ns

module tb_amber_periph_system;
    import amber_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int ACK_TIMEOUT     = 16;
    localparam int N_BOOT_WORDS    = 12;

    logic    i_clk;
    logic    i_arst_n;
    wb_adr_t i_wb_adr;
    wb_sel_t i_wb_sel;
    logic    i_wb_we;
    wb_dat_t i_wb_dat;
    logic    i_wb_cyc;
    logic    i_wb_stb;
    wb_dat_t o_wb_dat;
    logic    o_wb_ack;
    logic    o_wb_err;
    logic    o_irq;
    logic    o_firq;
    logic    o_led;

    // lcg state and boot memory model
    logic [31:0] lcg_state = 32'h5cf8;
    wb_dat_t     boot_model [int];
    int          boot_idx_q [$];

    amber_periph_system i_dut (
        .i_clk    ( i_clk    ),
        .i_arst_n ( i_arst_n ),
        .i_wb_adr ( i_wb_adr ),
        .i_wb_sel ( i_wb_sel ),
        .i_wb_we  ( i_wb_we  ),
        .i_wb_dat ( i_wb_dat ),
        .i_wb_cyc ( i_wb_cyc ),
        .i_wb_stb ( i_wb_stb ),
        .o_wb_dat ( o_wb_dat ),
        .o_wb_ack ( o_wb_ack ),
        .o_wb_err ( o_wb_err ),
        .o_irq    ( o_irq    ),
        .o_firq   ( o_firq   ),
        .o_led    ( o_led    )
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // budget for all tests plus reset
    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST + RESET_CYCLES) @(posedge i_clk);
        $display("watchdog expired before the tests completed");
        $display("Errors found");
        $fatal(1, "simulation stopped by watchdog");
    end

    // stop on the first bus protocol violation
    initial begin
        wait (i_dut.u_sva.n_fail != 0);
        $display("bus protocol assertion failed");
        $display("Errors found");
        $fatal(1, "bus protocol violation");
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // selected bytes from new and the rest from old
    function automatic wb_dat_t merge_selected(wb_dat_t old_dat, wb_dat_t new_dat, wb_sel_t sel);
        wb_dat_t res;
        res = old_dat;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_dat[8*b +: 8];
        end
        return res;
    endfunction

    function automatic wb_adr_t tmr_adr(int idx, tmr_reg_e r);
        return 32'h1300_0000 | (idx << 8) | (int'(r) << 2);
    endfunction

    function automatic wb_adr_t irq_adr(irq_reg_e r);
        return 32'h1400_0000 | (int'(r) << 2);
    endfunction

    function automatic wb_adr_t test_adr(test_reg_e r);
        return 32'hF000_0000 | (int'(r) << 2);
    endfunction

    function automatic wb_dat_t src_bit(irq_src_e s);
        return wb_dat_t'(1) << int'(s);
    endfunction

    task automatic check_dat(string name, wb_dat_t exp, wb_dat_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 32'h%08h, actual 32'h%08h", name, exp, act);
            $display("Errors found");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("Errors found");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge i_clk);
    endtask

    // --------------------------------------------------
    // bus tasks driven on the falling edge
    // --------------------------------------------------
    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                             input wb_dat_t wdat, output wb_dat_t rdat, output logic err);
        int waited;
        @(negedge i_clk);
        i_wb_adr = adr;
        i_wb_sel = sel;
        i_wb_we  = we;
        i_wb_dat = wdat;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        waited   = 0;
        // response sampled mid-cycle
        do begin
            @(negedge i_clk);
            waited++;
        end while (!o_wb_ack && !o_wb_err && waited < ACK_TIMEOUT);
        if (!o_wb_ack && !o_wb_err) begin
            $display("no ack or err from the bus at address %08h", adr);
            $display("Errors found");
            $fatal(1, "bus access timed out");
        end else begin
            rdat     = o_wb_dat;
            err      = o_wb_err;
            i_wb_cyc = 1'b0;
            i_wb_stb = 1'b0;
            i_wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t dat,
                            output logic err);
        wb_dat_t unused;
        wb_access(1'b1, adr, sel, dat, unused, err);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat, output logic err);
        wb_access(1'b0, adr, 4'hF, '0, dat, err);
    endtask

    // mapped register access where err must stay low
    task automatic reg_write(string name, wb_adr_t adr, wb_dat_t dat);
        logic err;
        wb_write(adr, 4'hF, dat, err);
        check_bit({name, " err"}, 1'b0, err);
    endtask

    task automatic reg_check(string name, wb_adr_t adr, wb_dat_t exp);
        logic    err;
        wb_dat_t dat;
        wb_read(adr, dat, err);
        check_bit({name, " err"}, 1'b0, err);
        check_dat(name, exp, dat);
    endtask

    // o_irq must rise within max_cycles
    task automatic wait_irq_high(string name, int max_cycles);
        int n;
        n = 0;
        while (!o_irq && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        check_bit(name, 1'b1, o_irq);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_defaults();
        check_bit("reset ack", 1'b0, o_wb_ack);
        check_bit("reset err", 1'b0, o_wb_err);
        check_bit("reset irq", 1'b0, o_irq);
        check_bit("reset firq", 1'b0, o_firq);
        check_bit("reset led", 1'b0, o_led);
        reg_check("reset boot mem", (next_rand() % 2048) << 2, '0);
        for (int t = 0; t < N_TIMERS; t++) begin
            for (int r = 0; r < 3; r++) begin
                reg_check($sformatf("reset timer %0d reg %0d", t, r),
                          tmr_adr(t, tmr_reg_e'(r)), '0);
            end
        end
        reg_check("reset irq enable", irq_adr(IRQ_EN_SET), '0);
        reg_check("reset firq enable", irq_adr(FIRQ_EN_SET), '0);
        reg_check("reset test id", test_adr(TST_ID), TEST_ID_VALUE);
    endtask

    task automatic boot_mem_readback();
        int      idx;
        wb_sel_t sel;
        wb_dat_t dat;
        wb_dat_t old;
        logic    err;
        for (int k = 0; k < N_BOOT_WORDS; k++) begin
            idx = next_rand() % 2048;
            dat = next_rand();
            // every third write a full word and the rest with random selects
            sel = (k % 3 == 0) ? 4'hF : wb_sel_t'(next_rand() >> 8);
            old = boot_model.exists(idx) ? boot_model[idx] : '0;
            boot_model[idx] = merge_selected(old, dat, sel);
            boot_idx_q.push_back(idx);
            wb_write(idx << 2, sel, dat, err);
            check_bit("boot write err", 1'b0, err);
        end
        foreach (boot_idx_q[i]) begin
            reg_check($sformatf("boot readback word %0d", boot_idx_q[i]),
                      boot_idx_q[i] << 2, boot_model[boot_idx_q[i]]);
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] r;
        logic [7:0]  region;
        wb_adr_t     adr;
        wb_dat_t     dat;
        logic        err;
        for (int k = 0; k < 4; k++) begin
            // pick an unmapped region
            do begin
                r      = next_rand();
                region = r[31:24];
            end while (region == 8'h00 || region == 8'h13 || region == 8'h14 ||
                       region == 8'hF0);
            // low bits alias a written boot word
            adr = {region, 24'(boot_idx_q[k] << 2)};
            wb_write(adr, 4'hF, next_rand(), err);
            check_bit("unmapped write err", 1'b1, err);
            check_bit("unmapped write ack", 1'b0, o_wb_ack);
            wb_read(adr, dat, err);
            check_bit("unmapped read err", 1'b1, err);
            check_bit("unmapped read ack", 1'b0, o_wb_ack);
            check_dat("unmapped read data", '0, dat);
            reg_check("boot word after unmapped write", boot_idx_q[k] << 2,
                      boot_model[boot_idx_q[k]]);
        end
    endtask

    task automatic irq_routing();
        reg_write("led on", test_adr(TST_LED), 32'h1);
        check_bit("led on", 1'b1, o_led);
        // test irq behind its enable
        reg_write("test irq set", test_adr(TST_IRQ), 32'h1);
        idle(2);
        check_bit("irq masked", 1'b0, o_irq);
        reg_check("irq raw", irq_adr(IRQ_RAW), src_bit(SRC_TEST));
        reg_write("irq enable", irq_adr(IRQ_EN_SET), src_bit(SRC_TEST));
        idle(1);
        check_bit("irq enabled", 1'b1, o_irq);
        reg_write("irq disable", irq_adr(IRQ_EN_CLR), src_bit(SRC_TEST));
        idle(1);
        check_bit("irq disabled", 1'b0, o_irq);
        reg_write("test irq clear", test_adr(TST_IRQ), 32'h0);
        // firq path is not visible on irq raw
        reg_write("test firq set", test_adr(TST_FIRQ), 32'h1);
        idle(2);
        check_bit("firq masked", 1'b0, o_firq);
        reg_check("firq raw", irq_adr(FIRQ_RAW), src_bit(SRC_TEST));
        reg_check("irq raw with firq", irq_adr(IRQ_RAW), '0);
        reg_write("firq enable", irq_adr(FIRQ_EN_SET), src_bit(SRC_TEST));
        idle(1);
        check_bit("firq enabled", 1'b1, o_firq);
        check_bit("irq stays low", 1'b0, o_irq);
        reg_write("firq disable", irq_adr(FIRQ_EN_CLR), src_bit(SRC_TEST));
        idle(1);
        check_bit("firq disabled", 1'b0, o_firq);
        reg_write("test firq clear", test_adr(TST_FIRQ), 32'h0);
        reg_write("led off", test_adr(TST_LED), 32'h0);
        check_bit("led off", 1'b0, o_led);
    endtask

    task automatic one_shot_timer();
        int load;
        load = 10 + next_rand() % 20;
        reg_write("one-shot load", tmr_adr(0, TMR_LOAD), load);
        reg_write("one-shot irq enable", irq_adr(IRQ_EN_SET), src_bit(SRC_TIMER0));
        reg_write("one-shot start", tmr_adr(0, TMR_CTRL), 32'h80);
        wait_irq_high("one-shot irq", load + 4);
        check_bit("one-shot firq", 1'b0, o_firq);
        reg_check("one-shot ctrl", tmr_adr(0, TMR_CTRL), '0);
        reg_check("one-shot value", tmr_adr(0, TMR_VALUE), '0);
        reg_write("one-shot clear", tmr_adr(0, TMR_CLR), 32'h0);
        idle(1);
        check_bit("one-shot irq cleared", 1'b0, o_irq);
        reg_write("one-shot irq disable", irq_adr(IRQ_EN_CLR), src_bit(SRC_TIMER0));
    endtask

    task automatic periodic_timer();
        int      load;
        logic    err;
        wb_dat_t val;
        load = 20 + next_rand() % 20;
        reg_write("periodic load", tmr_adr(1, TMR_LOAD), load);
        reg_write("periodic irq enable", irq_adr(IRQ_EN_SET), src_bit(SRC_TIMER1));
        reg_write("periodic start", tmr_adr(1, TMR_CTRL), 32'hC0);
        wait_irq_high("periodic first irq", load + 4);
        reg_check("periodic ctrl", tmr_adr(1, TMR_CTRL), 32'hC0);
        wb_read(tmr_adr(1, TMR_VALUE), val, err);
        check_bit("periodic value err", 1'b0, err);
        check_bit("periodic value in range", 1'b1, val <= wb_dat_t'(load));
        reg_write("periodic clear", tmr_adr(1, TMR_CLR), 32'h0);
        idle(1);
        check_bit("periodic irq cleared", 1'b0, o_irq);
        wait_irq_high("periodic second irq", load + 4);
        // stop and tidy up
        reg_write("periodic stop", tmr_adr(1, TMR_CTRL), 32'h0);
        reg_write("periodic final clear", tmr_adr(1, TMR_CLR), 32'h0);
        reg_write("periodic irq disable", irq_adr(IRQ_EN_CLR), src_bit(SRC_TIMER1));
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        i_arst_n = 1'b0;
        i_wb_adr = '0;
        i_wb_sel = '0;
        i_wb_we  = 1'b0;
        i_wb_dat = '0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_arst_n = 1'b1;
        reset_defaults();
        boot_mem_readback();
        unmapped_access();
        irq_routing();
        one_shot_timer();
        periodic_timer();
        $display("No errors");
        $finish;
    end

endmodule

// File: timer/timer_module.sv
`timescale 1ns/1ns

module timer_module #(
    parameter int N = amber_pkg::N_TIMERS
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_wr,
    input  amber_pkg::wb_adr_t i_adr,
    input  amber_pkg::wb_sel_t i_sel,
    input  amber_pkg::wb_dat_t i_dat,
    output amber_pkg::wb_dat_t o_rdat,
    output logic [N-1:0]       o_timer_int
);
    import amber_pkg::*;

    // per-timer state
    wb_dat_t      load  [N];
    wb_dat_t      count [N];
    logic [N-1:0] en;
    logic [N-1:0] per;
    logic [N-1:0] irq;

    logic [1:0]   tmr_idx;
    tmr_reg_e     reg_sel;
    logic         idx_ok;
    wb_dat_t      load_wdat;

    assign tmr_idx = i_adr[9:8];
    assign reg_sel = tmr_reg_e'(i_adr[3:2]);
    // index 3 is a hole when N < 4
    assign idx_ok  = (int'(tmr_idx) < N);

    assign load_wdat   = byte_merge(idx_ok ? load[tmr_idx] : '0, i_dat, i_sel);
    assign o_timer_int = irq;

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        o_rdat = '0;
        if (idx_ok) begin
            case (reg_sel)
                TMR_LOAD:  o_rdat = load[tmr_idx];
                TMR_VALUE: o_rdat = count[tmr_idx];
                TMR_CTRL: begin
                    o_rdat[TMR_CTRL_EN_BIT]  = en[tmr_idx];
                    o_rdat[TMR_CTRL_PER_BIT] = per[tmr_idx];
                end
                default:   o_rdat = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // down-counters and register writes
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int t = 0; t < N; t++) begin
                load[t]  <= '0;
                count[t] <= '0;
            end
            en  <= '0;
            per <= '0;
            irq <= '0;
        end else begin
            for (int t = 0; t < N; t++) begin
                if (en[t]) begin
                    if (count[t] == '0) begin
                        // zero reached, flag and reload or stop
                        irq[t] <= 1'b1;
                        if (per[t]) begin
                            count[t] <= load[t];
                        end else begin
                            en[t] <= 1'b0;
                        end
                    end else begin
                        count[t] <= count[t] - 1'b1;
                    end
                end
            end

            // bus write overrides the count step
            if (i_wr && idx_ok) begin
                case (reg_sel)
                    TMR_LOAD: begin
                        load[tmr_idx]  <= load_wdat;
                        count[tmr_idx] <= load_wdat;
                    end
                    TMR_CTRL: begin
                        if (i_sel[0]) begin
                            en[tmr_idx]  <= i_dat[TMR_CTRL_EN_BIT];
                            per[tmr_idx] <= i_dat[TMR_CTRL_PER_BIT];
                        end
                    end
                    TMR_CLR:  irq[tmr_idx] <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

endmodule
